//--- logic/tree_route_config.svh
// ==================================================
// tree shape for the route unit, K-ary and L layers
// K should be a power of two so every digit code is a port
// both values need to be at least 2
// ==================================================
`ifndef TREE_ROUTE_CONFIG_SVH
`define TREE_ROUTE_CONFIG_SVH

// ==================================================
// arity
// ==================================================
// number of down ports per router; port K is always up
`define TREE_K 2

// ==================================================
// height
// ==================================================
// layer 0 holds the leaves, layer TREE_L-1 is the root
// endpoints in the whole tree = TREE_K ** TREE_L
`define TREE_L 3

`endif

//--- logic/tree_route_pkg.sv
// ==================================================
// shared widths and types for the tree route unit
// widths follow from the config defines only
// ==================================================
package tree_route_pkg;

`include "tree_route_config.svh"

    // ==================================================
    // derived sizes
    // ==================================================
    localparam int K  = `TREE_K;
    localparam int L  = `TREE_L;
    localparam int KW = (K > 2) ? $clog2(K) : 1;     // bits per digit
    localparam int LW = (L > 1) ? $clog2(L) : 1;     // bits per layer number
    localparam int PW = $clog2(K + 1);               // down ports plus one up
    localparam int AW = L * KW;                      // full address width

    // ==================================================
    // types
    // ==================================================
    typedef logic [KW-1:0] digit_t;       // one address digit
    typedef logic [AW-1:0] tree_addr_t;   // endpoint address or router position
    typedef logic [LW-1:0] layer_t;       // router layer
    typedef logic [PW-1:0] port_t;        // binary output port
    typedef logic [K-1:0]  port_mask_t;   // one-hot, arrival port removed

    // up port sits above all the down ports
    localparam port_t PORT_UP = port_t'(K);

endpackage

//--- logic/route_req_if.sv
`timescale 1ns/1ps
// ==================================================
// registered route request between stage and decoder
// one request per cycle while valid is high, never refused
// ==================================================
interface route_req_if;
    import tree_route_pkg::*;

    logic       valid;       // request present this cycle
    tree_addr_t dest_addr;   // destination endpoint
    port_t      dest_port;   // current-hop output port
    port_t      in_port;     // port the header came in on

    // driven by the stage register
    modport stage (
        output valid,
        output dest_addr,
        output dest_port,
        output in_port
    );

    // readers of the registered request
    modport sink (
        input  valid,
        input  dest_addr,
        input  dest_port,
        input  in_port
    );

endinterface

//--- logic/tree_nca_route.sv
`timescale 1ns/1ps
// ==================================================
// nearest-common-ancestor port select, no latency
// a layer strap above L-1 selects nothing and routes down on port 0
// ==================================================
module tree_nca_route (
    input  tree_route_pkg::tree_addr_t current_pos,     // own position digits
    input  tree_route_pkg::layer_t     current_layer,   // own layer
    input  tree_route_pkg::tree_addr_t dest_addr,       // destination endpoint
    output tree_route_pkg::port_t      dest_port        // chosen output port
);
    import tree_route_pkg::*;

    digit_t dest_digit [L];
    digit_t pos_digit  [L];
    logic   go_up;
    digit_t down_digit;

    // split both addresses into digits
    for (genvar g = 0; g < L; g++) begin : g_digit
        assign dest_digit[g] = dest_addr[g*KW +: KW];
        assign pos_digit[g]  = current_pos[g*KW +: KW];
    end

    // ==================================================
    // subtree test and down digit select
    // ==================================================
    always_comb begin
        go_up      = 1'b0;
        down_digit = '0;
        for (int i = 0; i < L; i++) begin
            // digits above own layer must match own position
            if (layer_t'(i) > current_layer && dest_digit[i] != pos_digit[i]) begin
                go_up = 1'b1;
            end
            if (layer_t'(i) == current_layer) begin
                down_digit = dest_digit[i];   // branch taken at this layer
            end
        end
    end

    // root has no digits above it, so it never goes up
    assign dest_port = go_up ? PORT_UP : port_t'(down_digit);

endmodule

//--- logic/tree_neighbor_addr.sv
`timescale 1ns/1ps
// ==================================================
// position and layer of the router behind a port
// down from a leaf leads to an endpoint, result is then meaningless
// up from the root is not expected
// ==================================================
module tree_neighbor_addr (
    input  tree_route_pkg::tree_addr_t current_pos,     // own position digits
    input  tree_route_pkg::layer_t     current_layer,   // own layer
    input  tree_route_pkg::port_t      dest_port,       // port being taken
    output tree_route_pkg::tree_addr_t next_pos,        // neighbour position
    output tree_route_pkg::layer_t     next_layer       // neighbour layer
);
    import tree_route_pkg::*;

    logic   go_up;
    layer_t up_layer;
    layer_t down_layer;
    digit_t down_digit;

    assign go_up      = (dest_port == PORT_UP);
    assign up_layer   = current_layer + 1'b1;        // parent layer
    assign down_layer = current_layer - 1'b1;        // child layer
    assign down_digit = digit_t'(dest_port);         // down ports fit a digit

    // ==================================================
    // digit update
    // ==================================================
    always_comb begin
        next_pos = current_pos;
        if (go_up) begin
            // parent keeps digits above its own layer, its branch digit drops
            for (int i = 0; i < L; i++) begin
                if (layer_t'(i) == up_layer) begin
                    next_pos[i*KW +: KW] = '0;
                end
            end
        end else begin
            // child is told apart by the digit at our own layer
            for (int i = 0; i < L; i++) begin
                if (layer_t'(i) == current_layer) begin
                    next_pos[i*KW +: KW] = down_digit;
                end
            end
        end
    end

    assign next_layer = go_up ? up_layer : down_layer;

endmodule

//--- logic/tree_lookahead_route.sv
`timescale 1ns/1ps
// ==================================================
// header stage register plus next-hop route, 1 cycle
// straps are registered with the header, so they may change per header
// lk_port is only meaningful while lk_valid is high
// ==================================================
module tree_lookahead_route (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       hdr_valid,
    input  tree_route_pkg::tree_addr_t dest_addr,      // destination endpoint
    input  tree_route_pkg::port_t      dest_port,      // current-hop port
    input  tree_route_pkg::port_t      in_port,        // arrival port
    input  tree_route_pkg::layer_t     router_layer,   // layer strap
    input  tree_route_pkg::tree_addr_t router_pos,     // position strap
    route_req_if.stage                 req,
    output logic                       lk_valid,
    output tree_route_pkg::port_t      lk_port
);
    import tree_route_pkg::*;

    logic       valid_q;
    tree_addr_t addr_q;
    port_t      port_q;
    port_t      in_port_q;
    layer_t     layer_q;
    tree_addr_t pos_q;
    tree_addr_t next_pos;
    layer_t     next_layer;
    logic       to_endpoint;

    // ==================================================
    // stage register
    // ==================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q   <= 1'b0;
            addr_q    <= '0;
            port_q    <= '0;
            in_port_q <= '0;
            layer_q   <= '0;
            pos_q     <= '0;
        end else begin
            valid_q   <= hdr_valid;
            addr_q    <= dest_addr;
            port_q    <= dest_port;
            in_port_q <= in_port;
            layer_q   <= router_layer;
            pos_q     <= router_pos;
        end
    end

    assign req.valid     = valid_q;
    assign req.dest_addr = addr_q;
    assign req.dest_port = port_q;
    assign req.in_port   = in_port_q;

    // ==================================================
    // next hop
    // ==================================================
    tree_neighbor_addr u_neighbor (
        .current_pos   (pos_q),
        .current_layer (layer_q),
        .dest_port     (port_q),
        .next_pos      (next_pos),
        .next_layer    (next_layer)
    );

    tree_nca_route u_next_nca (
        .current_pos   (next_pos),
        .current_layer (next_layer),
        .dest_addr     (req.dest_addr),
        .dest_port     (lk_port)
    );

    // a down port on a leaf feeds an endpoint, no router to route for
    assign to_endpoint = (layer_q == '0) && (port_q != PORT_UP);
    assign lk_valid    = valid_q && !to_endpoint;

endmodule

//--- logic/tree_port_decoder.sv
`timescale 1ns/1ps
// ==================================================
// binary port to one-hot crossbar request
// arrival port bit is squeezed out, so K bits remain
// ==================================================
module tree_port_decoder (
    route_req_if.sink                  req,
    output logic                       route_valid,
    output tree_route_pkg::port_mask_t port_mask
);
    import tree_route_pkg::*;

    logic [K:0] port_onehot;   // all K+1 ports
    port_mask_t masked;

    // out-of-range codes give an all-zero one-hot
    always_comb begin
        for (int j = 0; j <= K; j++) begin
            port_onehot[j] = (req.dest_port == port_t'(j));
        end
    end

    // bits above the arrival port shift down by one
    always_comb begin
        for (int j = 0; j < K; j++) begin
            if (port_t'(j) < req.in_port) begin
                masked[j] = port_onehot[j];
            end else begin
                masked[j] = port_onehot[j+1];
            end
        end
    end

    assign route_valid = req.valid;
    assign port_mask   = req.valid ? masked : '0;   // quiet when idle

endmodule

//--- logic/tree_route_unit.sv
`timescale 1ns/1ps
// ==================================================
// route unit for one tree router, 1 cycle header to result
// accepts a header every cycle, no back-pressure
// straps must describe a real router of the configured tree
// ==================================================
module tree_route_unit (
    input  logic                       clk,
    input  logic                       reset,

    // header side
    input  logic                       hdr_valid,      // header present
    input  tree_route_pkg::tree_addr_t dest_addr,      // destination endpoint
    input  tree_route_pkg::port_t      in_port,        // arrival port

    // router straps
    input  tree_route_pkg::layer_t     router_layer,   // 0 is leaf
    input  tree_route_pkg::tree_addr_t router_pos,     // digits up to layer are zero

    // route result
    output logic                       route_valid,
    output tree_route_pkg::port_mask_t port_mask,      // one-hot, arrival removed
    output tree_route_pkg::port_t      dest_port,      // binary current-hop port
    output logic                       lk_valid,       // next hop is a router
    output tree_route_pkg::port_t      lk_port         // port at the next router
);
    import tree_route_pkg::*;

    port_t cur_port;   // current-hop port before the stage

    route_req_if req_if ();

    // ==================================================
    // current hop
    // ==================================================
    tree_nca_route u_cur_nca (
        .current_pos   (router_pos),
        .current_layer (router_layer),
        .dest_addr     (dest_addr),
        .dest_port     (cur_port)
    );

    // ==================================================
    // stage and look-ahead
    // ==================================================
    tree_lookahead_route u_lookahead (
        .clk          (clk),
        .reset        (reset),
        .hdr_valid    (hdr_valid),
        .dest_addr    (dest_addr),
        .dest_port    (cur_port),
        .in_port      (in_port),
        .router_layer (router_layer),
        .router_pos   (router_pos),
        .req          (req_if.stage),
        .lk_valid     (lk_valid),
        .lk_port      (lk_port)
    );

    // ==================================================
    // crossbar request
    // ==================================================
    tree_port_decoder u_decoder (
        .req         (req_if.sink),
        .route_valid (route_valid),
        .port_mask   (port_mask)
    );

    assign dest_port = req_if.dest_port;   // registered binary port

endmodule

//--- tb/tree_route_chk.sv
`timescale 1ns/1ps
// ==================================================
// bound assertions on the tree route unit
// reference routes are rebuilt from the inputs one cycle back
// straps are assumed to name a real router of the tree
// ==================================================
`include "tree_route_config.svh"

module tree_route_chk (
    input logic                       clk,
    input logic                       reset,
    input logic                       hdr_valid,
    input tree_route_pkg::tree_addr_t dest_addr,
    input tree_route_pkg::port_t      in_port,
    input tree_route_pkg::layer_t     router_layer,
    input tree_route_pkg::tree_addr_t router_pos,
    input logic                       route_valid,
    input tree_route_pkg::port_mask_t port_mask,
    input tree_route_pkg::port_t      dest_port,
    input logic                       lk_valid,
    input tree_route_pkg::port_t      lk_port
);
    localparam int RK = `TREE_K;
    localparam int RL = `TREE_L;
    localparam int DW = ($clog2(RK) < 1) ? 1 : $clog2(RK);   // digit width
    localparam int AB = RL * DW;

    int error_count = 0;   // read by the testbench

    // ==================================================
    // reference model of the address rule
    // ==================================================
    function automatic int digit_of(input logic [AB-1:0] addr, input int n);
        return int'((addr >> (n * DW)) & AB'((1 << DW) - 1));
    endfunction

    function automatic logic [AB-1:0] set_digit(input logic [AB-1:0] addr, input int n,
                                                input int value);
        logic [AB-1:0] field;
        logic [AB-1:0] result;
        result = addr;
        if (n >= 0 && n < RL) begin
            field  = AB'((1 << DW) - 1) << (n * DW);
            result = (addr & ~field) | ((AB'(value) << (n * DW)) & field);
        end
        return result;
    endfunction

    // down on digit l unless a digit above l differs from the position
    function automatic int route_ref(input logic [AB-1:0] pos, input int layer,
                                     input logic [AB-1:0] dest);
        int port;
        port = digit_of(dest, layer);
        for (int n = layer + 1; n < RL; n++) begin
            if (digit_of(dest, n) != digit_of(pos, n)) begin
                port = RK;
            end
        end
        return port;
    endfunction

    // same rule at the parent or child behind the chosen port
    function automatic int next_hop_ref(input logic [AB-1:0] pos, input int layer,
                                        input logic [AB-1:0] dest);
        int port;
        port = route_ref(pos, layer, dest);
        if (port == RK) begin
            return route_ref(set_digit(pos, layer + 1, 0), layer + 1, dest);
        end
        return route_ref(set_digit(pos, layer, port), layer - 1, dest);
    endfunction

    // one-hot over the K+1 ports with the arrival slot squeezed out
    function automatic logic [RK-1:0] mask_ref(input int port, input int arrival);
        logic [RK-1:0] mask;
        int slot;
        mask = '0;
        slot = 0;
        for (int p = 0; p <= RK; p++) begin
            if (p != arrival) begin
                if (p == port && slot < RK) begin
                    mask[slot] = 1'b1;
                end
                slot++;
            end
        end
        return mask;
    endfunction

    // ==================================================
    // assertions
    // ==================================================
    assert property (@(posedge clk) (reset && $past(reset))
        |-> !route_valid && !lk_valid && port_mask == '0)
    else begin
        error_count++;
        $error("CHECK FAILED t=%0t outputs active during reset", $time);
    end

    assert property (@(posedge clk) disable iff (reset) route_valid == $past(hdr_valid))
    else begin
        error_count++;
        $error("CHECK FAILED t=%0t route_valid %0b not one cycle after header", $time,
               route_valid);
    end

    assert property (@(posedge clk) disable iff (reset) !$past(hdr_valid)
        |-> !route_valid && !lk_valid)
    else begin
        error_count++;
        $error("CHECK FAILED t=%0t valid output without a header", $time);
    end

    assert property (@(posedge clk) disable iff (reset) route_valid
        |-> int'(dest_port) == route_ref($past(router_pos), int'($past(router_layer)),
                                         $past(dest_addr)))
    else begin
        error_count++;
        $error("CHECK FAILED t=%0t dest_port %0d wrong", $time, dest_port);
    end

    assert property (@(posedge clk) disable iff (reset)
        port_mask == ($past(hdr_valid)
            ? mask_ref(route_ref($past(router_pos), int'($past(router_layer)),
                                 $past(dest_addr)), int'($past(in_port)))
            : '0))
    else begin
        error_count++;
        $error("CHECK FAILED t=%0t port_mask %b wrong", $time, port_mask);
    end

    // a down port at a leaf ends at an endpoint
    assert property (@(posedge clk) disable iff (reset)
        lk_valid == ($past(hdr_valid) && !(int'($past(router_layer)) == 0
            && route_ref($past(router_pos), 0, $past(dest_addr)) != RK)))
    else begin
        error_count++;
        $error("CHECK FAILED t=%0t lk_valid %0b wrong", $time, lk_valid);
    end

    assert property (@(posedge clk) disable iff (reset) lk_valid
        |-> int'(lk_port) == next_hop_ref($past(router_pos), int'($past(router_layer)),
                                          $past(dest_addr)))
    else begin
        error_count++;
        $error("CHECK FAILED t=%0t lk_port %0d wrong", $time, lk_port);
    end

endmodule

bind tree_route_unit tree_route_chk u_chk (.*);

//--- tb/tb_tree_route_unit.sv
`timescale 1ns/1ps
// ==================================================
// testbench for the tree route unit
// the bound checker holds the reference model
// needs at least 3 layers for a middle router
// ==================================================
module tb_tree_route_unit;
    import tree_route_pkg::*;

    localparam int TEST_CYCLES = 500;               // about reset plus all six tests
    localparam int MAX_CYCLES  = 4 * TEST_CYCLES;

    logic        clk;
    logic        reset;
    logic        hdr_valid;
    tree_addr_t  dest_addr;
    port_t       in_port;
    layer_t      router_layer;
    tree_addr_t  router_pos;
    logic        route_valid;
    port_mask_t  port_mask;
    port_t       dest_port;
    logic        lk_valid;
    port_t       lk_port;

    logic [31:0] lfsr_state    = 32'h0c5603ac;
    int          cycle_count   = 0;
    int          header_count  = 0;
    int          test_count    = 0;
    int          errors_before = 0;

    tree_route_unit dut (.*);

    always #2 clk = ~clk;   // 4 ns period

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // ==================================================
    // Galois LFSR random source
    // ==================================================
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'hD000_0001;
        end
        return next;
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value      = {value[30:0], lfsr_state[0]};   // one step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    function automatic tree_addr_t random_addr();
        return tree_addr_t'(random_bits(AW));
    endfunction

    function automatic port_t random_in_port();
        return port_t'(random_bits(PW) % (K + 1));
    endfunction

    // digits 0 to layer that a router at that layer does not fix
    function automatic tree_addr_t low_digits(input layer_t layer);
        tree_addr_t mask;
        mask = '0;
        for (int i = 0; i < L; i++) begin
            if (i <= int'(layer)) begin
                mask[i*KW +: KW] = '1;
            end
        end
        return mask;
    endfunction

    // ==================================================
    // stimulus tasks
    // ==================================================
    task automatic send_header(input tree_addr_t addr, input port_t port,
                               input layer_t layer, input tree_addr_t pos);
        @(posedge clk);
        hdr_valid    <= 1'b1;
        dest_addr    <= addr;
        in_port      <= port;
        router_layer <= layer;
        router_pos   <= pos;
        header_count++;
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(posedge clk);
            hdr_valid <= 1'b0;
            dest_addr <= random_addr();   // junk on the bus while idle
            in_port   <= random_in_port();
        end
    endtask

    task automatic report_test(input string name);
        idle_cycles(3);   // last header out of the stage and checked
        @(negedge clk);
        test_count++;
        $display("test %0d %s: %0d errors", test_count, name,
                 dut.u_chk.error_count - errors_before);
        errors_before = dut.u_chk.error_count;
    endtask

    // ==================================================
    // test sequence
    // ==================================================
    initial begin
        layer_t     layer;
        tree_addr_t pos;
        tree_addr_t flip;
        clk          = 1'b0;
        reset        = 1'b1;
        hdr_valid    = 1'b0;
        dest_addr    = '0;
        in_port      = '0;
        router_layer = '0;
        router_pos   = '0;
        flip         = tree_addr_t'(1) << ((L - 1) * KW);   // changes the top digit

        repeat (8) @(posedge clk);
        reset <= 1'b0;
        report_test("reset state");

        for (int r = 0; r < 4; r++) begin
            layer = '0;
            pos   = random_addr() & ~low_digits(layer);
            for (int d = 0; d < K; d++) begin
                send_header(pos | tree_addr_t'(d), random_in_port(), layer, pos);
                idle_cycles(r % 2);
            end
        end
        report_test("leaf local delivery");

        for (int r = 0; r < 2; r++) begin   // leaf then middle router
            layer = layer_t'(r);
            pos   = random_addr() & ~low_digits(layer);
            repeat (6) begin
                send_header((pos | (random_addr() & low_digits(layer))) ^ flip,
                            random_in_port(), layer, pos);
            end
        end
        report_test("up routing");

        for (int r = 0; r < 2; r++) begin   // root then middle router
            layer = (r == 0) ? layer_t'(L - 1) : layer_t'(1);
            pos   = random_addr() & ~low_digits(layer);
            repeat (6) begin
                send_header(pos | (random_addr() & low_digits(layer)),
                            random_in_port(), layer, pos);
            end
        end
        report_test("down routing");

        repeat (200) begin
            layer = layer_t'(random_bits(LW) % L);
            pos   = random_addr() & ~low_digits(layer);
            send_header(random_addr(), random_in_port(), layer, pos);
        end
        report_test("random back to back");

        repeat (100) begin
            layer = layer_t'(random_bits(LW) % L);
            pos   = random_addr() & ~low_digits(layer);
            send_header(random_addr(), random_in_port(), layer, pos);
            idle_cycles(int'(random_bits(2)));
        end
        report_test("idle gaps");

        $display("summary: %0d tests, %0d headers, %0d errors", test_count, header_count,
                 dut.u_chk.error_count);
        if (dut.u_chk.error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+logic
logic/tree_route_pkg.sv
logic/route_req_if.sv
logic/tree_nca_route.sv
logic/tree_neighbor_addr.sv
logic/tree_lookahead_route.sv
logic/tree_port_decoder.sv
logic/tree_route_unit.sv
tb/tree_route_chk.sv
tb/tb_tree_route_unit.sv

//--- Makefile
# Verilator build and run for the tree route unit testbench

TOP = tb_tree_route_unit
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

obj_dir/V$(TOP): filelist.f logic/*.sv logic/*.svh tb/*.sv
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o V$(TOP)

test: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) +verilator+error+limit+10000 > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "test failed, no result line"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf obj_dir $(LOG)
